/* compile.f */
source/flashPkg.sv
source/busPkg.sv
source/pageReadController.sv
source/wishboneRomSlave.sv
source/romSubsystem.sv
test/flashModel.sv
test/romSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the romSubsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module romSubsystemTb -f compile.f -Mdir obj_dir

status=0
./obj_dir/VromSubsystemTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
	echo "Simulation did not complete, see sim.log"
	exit 1
fi

exit 0

/* source/busPkg.sv */
package busPkg;

	////////////////////////////////////////////////////////////
	// Wishbone port sizing
	////////////////////////////////////////////////////////////

	// One bus address per flash word
	localparam int wbAddrBits = flashPkg::romAddrBits;

	// Bus data matches the flash word
	localparam int wbDataBits = flashPkg::wordBits;

	// Address on adr
	typedef logic [wbAddrBits-1:0] wbAddr;

	// Data on the read and write data lines
	typedef logic [wbDataBits-1:0] wbData;

endpackage

/* source/flashPkg.sv */
package flashPkg;

	////////////////////////////////////////////////////////////
	// Flash geometry
	////////////////////////////////////////////////////////////

	// Word address width of the whole array
	localparam int romAddrBits = 23;

	// Word select inside one page, eight words per page
	localparam int pageBits = 3;

	// Data bus width in word mode
	localparam int wordBits = 16;

	////////////////////////////////////////////////////////////
	// Read access timing, in clock cycles
	////////////////////////////////////////////////////////////

	// First access into a new page
	localparam int defaultMissCycles = 4;

	// Access to another word of the open page
	localparam int defaultHitCycles = 2;

	// One data word on the flash pins
	typedef logic [wordBits-1:0] flashWord;

	// Word address as seen by the controller
	typedef logic [romAddrBits-1:0] romAddr;

	// Byte address on the pins, one bit wider than the word address
	typedef logic [romAddrBits:0] pinAddr;

endpackage

/* source/pageReadController.sv */
module pageReadController #(
	parameter int missCycles = flashPkg::defaultMissCycles,
	parameter int hitCycles = flashPkg::defaultHitCycles
) (
	input logic clk,
	input logic rst,

	// Request side
	input flashPkg::romAddr addr,
	input logic load,
	output flashPkg::flashWord data,
	output logic ready,

	// Flash pins
	input flashPkg::flashWord flashData,
	output flashPkg::pinAddr flashAddr,
	output logic flashChipEn,
	output logic flashOutEn,
	output logic flashWriteEn,
	output logic flashByte
);
	import flashPkg::*;

	// Counter must reach the longest wait
	localparam int countBits = $clog2(missCycles + 1);

	// Page number is the address above the word select
	localparam int tagBits = romAddrBits - pageBits;

	// Open page and word currently on the pins
	logic [tagBits-1:0] openPage;
	logic [pageBits-1:0] openWord;

	// Wait chosen at load and cycles spent so far
	logic [countBits-1:0] waitCycles;
	logic [countBits-1:0] count;

	// Page of the incoming request
	logic [tagBits-1:0] reqPage;
	logic pageHit;

	////////////////////////////////////////////////////////////
	// Pin side
	////////////////////////////////////////////////////////////

	// Chip held in asynchronous read
	// Enables are active low, word mode selected
	assign flashChipEn = 1'b0;
	assign flashOutEn = 1'b0;
	assign flashWriteEn = 1'b1;
	assign flashByte = 1'b1;

	// Byte address, lowest bit unused in word mode
	assign flashAddr = {openPage, openWord, 1'b0};

	// Pins pass straight through
	// Only trusted once ready is high
	assign data = flashData;

	////////////////////////////////////////////////////////////
	// Page tracking and access timer
	////////////////////////////////////////////////////////////

	assign reqPage = addr[romAddrBits-1:pageBits];

	// Same page means the sense amplifiers already hold it
	assign pageHit = (reqPage == openPage);

	always_ff @(posedge clk) begin
		if (!rst) begin
			// Page zero counts as open, nothing left to wait for
			openPage <= '0;
			openWord <= '0;
			waitCycles <= '0;
			count <= '0;
		end else if (load) begin
			// Pick the wait from the page compare before the page moves
			if (pageHit) begin
				waitCycles <= countBits'(hitCycles);
			end else begin
				waitCycles <= countBits'(missCycles);
			end
			openPage <= reqPage;
			openWord <= addr[pageBits-1:0];
			count <= '0;
		end else if (!ready) begin
			count <= count + 1'b1;
		end
	end

	// Data valid once the chosen number of edges has passed
	assign ready = (count >= waitCycles);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// A finished access stays finished until the next request
	assert property (@(posedge clk) disable iff (!rst) (ready && !load) |=> ready)
		else $error("ready fell without load");

	// Requester must wait for the current access to finish
	assert property (@(posedge clk) disable iff (!rst) load |-> ready)
		else $error("load while ready low");

endmodule

/* source/romSubsystem.sv */
module romSubsystem #(
	parameter int missCycles = flashPkg::defaultMissCycles,
	parameter int hitCycles = flashPkg::defaultHitCycles
) (
	input logic clk,
	input logic rst,

	// Wishbone classic slave port
	input logic cyc,
	input logic stb,
	input logic we,
	input busPkg::wbAddr adr,
	// Writes are refused, write data never consumed
	input busPkg::wbData wrData,
	output busPkg::wbData rdData,
	output logic ack,
	output logic err,

	// Parallel NOR flash pins
	output flashPkg::pinAddr flashAddr,
	input flashPkg::flashWord flashData,
	output logic flashChipEn,
	output logic flashOutEn,
	output logic flashWriteEn,
	output logic flashByte
);
	import flashPkg::*;

	////////////////////////////////////////////////////////////
	// Slave to controller link
	////////////////////////////////////////////////////////////

	// Start of a flash read and its word address
	logic readLoad;
	romAddr readAddr;

	// Access finished and the word on the pins
	logic readReady;
	flashWord readData;

	// Bus protocol and response timing
	wishboneRomSlave slave0 (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.rdData(rdData),
		.ack(ack),
		.err(err),
		.load(readLoad),
		.romAddr(readAddr),
		.romData(readData),
		.ready(readReady)
	);

	// Page tracking and flash pin control
	pageReadController #(
		.missCycles(missCycles),
		.hitCycles(hitCycles)
	) pageCtrl0 (
		.clk(clk),
		.rst(rst),
		.addr(readAddr),
		.load(readLoad),
		.data(readData),
		.ready(readReady),
		.flashData(flashData),
		.flashAddr(flashAddr),
		.flashChipEn(flashChipEn),
		.flashOutEn(flashOutEn),
		.flashWriteEn(flashWriteEn),
		.flashByte(flashByte)
	);

endmodule

/* source/wishboneRomSlave.sv */
module wishboneRomSlave (
	input logic clk,
	input logic rst,

	// Wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input busPkg::wbAddr adr,
	output busPkg::wbData rdData,
	output logic ack,
	output logic err,

	// Toward the page controller
	output logic load,
	output flashPkg::romAddr romAddr,
	input flashPkg::flashWord romData,
	input logic ready
);
	import busPkg::*;

	// Waiting covers a read in flight
	// Closing is the dead cycle after ack or err
	typedef enum logic [1:0] {
		idle,
		waiting,
		closing
	} slaveState;

	slaveState state;
	slaveState nextState;

	// Cycle and strobe both present
	logic request;

	// Closing was entered from a refused write
	logic wasWrite;

	assign request = cyc && stb;

	////////////////////////////////////////////////////////////
	// Request and response
	////////////////////////////////////////////////////////////

	// One-cycle load, only from idle, so the controller sees it on the sampling edge
	assign load = (state == idle) && request && !we;

	// Address goes through untouched, one bus address per flash word
	assign romAddr = adr;

	// Read data straight from the controller
	assign rdData = wbData'(romData);

	// Ack on the first cycle the controller reports valid data
	assign ack = (state == waiting) && ready && request;

	// Error shows in the cycle after the write was sampled
	assign err = (state == closing) && wasWrite && request;

	////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (request && we) begin
					nextState = closing;
				end else if (request) begin
					nextState = waiting;
				end
			end
			// ready is low here until the access finishes
			waiting: begin
				if (ready) begin
					nextState = closing;
				end
			end
			// Held strobe is not taken as a new request
			closing: nextState = idle;
			default: nextState = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= idle;
			wasWrite <= 1'b0;
		end else begin
			state <= nextState;
			// Remember why closing was entered
			if (state == idle) begin
				wasWrite <= request && we;
			end
		end
	end

	// Each response lasts a single cycle
	assert property (@(posedge clk) disable iff (!rst) (ack || err) |=> !(ack || err))
		else $error("response held for more than one cycle");

	// Error only answers a write taken in idle
	assert property (@(posedge clk) disable iff (!rst)
		err |-> $past((state == idle) && request && we))
		else $error("err without a sampled write");

endmodule

/* test/flashModel.sv */
module flashModel #(
	parameter int missCycles = flashPkg::defaultMissCycles,
	parameter int hitCycles = flashPkg::defaultHitCycles
) (
	input logic clk,
	input flashPkg::pinAddr addr,
	input logic chipEn,
	input logic outEn,
	input logic writeEn,
	input logic byteMode,
	output flashPkg::flashWord data
);
	timeunit 1ns;
	timeprecision 1ps;
	import flashPkg::*;

	// Word address last seen on the pins, page zero open at power up
	romAddr heldAddr = '0;

	// Cycles since the last address change
	int age = missCycles;

	// Last change moved to another page
	logic heldMiss = 1'b0;

	// Array contents: low address bits scrambled, rotated by the page number
	function automatic flashWord wordAt(input romAddr a);
		flashWord mixed;
		int rot;
		mixed = a[15:0] ^ 16'h5A3C;
		rot = int'(a[6:3]);
		return (mixed << rot) | (mixed >> (16 - rot));
	endfunction

	////////////////////////////////////////////////////////////
	// Access timer
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (addr[romAddrBits:1] != heldAddr) begin
			// New page needs the full access, same page only the page-mode access
			heldMiss <= addr[romAddrBits:pageBits+1] != heldAddr[romAddrBits-1:pageBits];
			heldAddr <= addr[romAddrBits:1];
			age <= 1;
		end else if (age < missCycles) begin
			age <= age + 1;
		end
	end

	// Output is unknown while disabled, in byte mode, or until the access time is over
	always_comb begin
		if (chipEn || outEn || !writeEn || !byteMode) begin
			data = 'x;
		end else if (addr[romAddrBits:1] != heldAddr) begin
			data = 'x;
		end else if (age < (heldMiss ? missCycles : hitCycles)) begin
			data = 'x;
		end else begin
			data = wordAt(heldAddr);
		end
	end

endmodule

/* test/romSubsystemTb.sv */
module romSubsystemTb;
	timeunit 1ns;
	timeprecision 1ps;
	import flashPkg::*;
	import busPkg::*;

	localparam int missCycles = defaultMissCycles;
	localparam int hitCycles = defaultHitCycles;
	localparam int clkPeriod = 20;
	localparam int resetCycles = 8;
	localparam int fixedRows = 11;
	localparam int randomRows = 20;
	localparam int tableRows = fixedRows + randomRows;
	// Longest transfer plus gap stays under missCycles + 4
	localparam int watchdogCycles = 2 * (tableRows * (missCycles + 4) + resetCycles);

	// One table row: direction, word address, err expected
	typedef struct packed {
		logic we;
		romAddr addr;
		logic expErr;
	} stimRow;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	wbAddr adr;
	wbData wrData;
	wbData rdData;
	logic ack;
	logic err;
	pinAddr flashAddr;
	flashWord flashData;
	logic flashChipEn;
	logic flashOutEn;
	logic flashWriteEn;
	logic flashByte;

	stimRow stimTable[tableRows];
	int rowFill;
	int errorCount;
	int checkCount;
	integer seed;

	// Reference for the open page, page zero after reset
	logic [romAddrBits-pageBits-1:0] openPage;

	romSubsystem #(
		.missCycles(missCycles),
		.hitCycles(hitCycles)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.wrData(wrData),
		.rdData(rdData),
		.ack(ack),
		.err(err),
		.flashAddr(flashAddr),
		.flashData(flashData),
		.flashChipEn(flashChipEn),
		.flashOutEn(flashOutEn),
		.flashWriteEn(flashWriteEn),
		.flashByte(flashByte)
	);

	flashModel #(
		.missCycles(missCycles),
		.hitCycles(hitCycles)
	) flash0 (
		.clk(clk),
		.addr(flashAddr),
		.chipEn(flashChipEn),
		.outEn(flashOutEn),
		.writeEn(flashWriteEn),
		.byteMode(flashByte),
		.data(flashData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Backstop in case the DUT never answers
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles, run stopped", watchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkData(input string sigName, input flashWord got, input flashWord exp);
		checkCount++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, sigName, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkLatency(input string sigName, input int got, input int exp);
		checkCount++;
		if (got != exp) begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, sigName, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkErr(input string sigName, input bit got, input bit exp);
		checkCount++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %b expected %b", $time, sigName, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkPinAddr(input string sigName, input pinAddr got, input pinAddr exp);
		checkCount++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, sigName, got, exp);
			errorCount++;
		end
	endtask

	// Flash word from the address rule, rotate done bit by bit
	function automatic flashWord expectedWord(input romAddr a);
		flashWord w;
		int turns;
		w = a[15:0] ^ 16'h5A3C;
		turns = int'(a[6:3]);
		for (int k = 0; k < turns; k++) begin
			w = {w[14:0], w[15]};
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	task automatic putRow(input logic rowWe, input romAddr rowAddr, input logic rowErr);
		stimTable[rowFill] = '{rowWe, rowAddr, rowErr};
		rowFill++;
	endtask

	task automatic buildTable();
		logic [31:0] draw;
		romAddr prevAddr;
		romAddr nextAddr;
		// Hit in page 0, then a miss and a hit
		putRow(1'b0, 23'h000005, 1'b0);
		putRow(1'b0, 23'h012344, 1'b0);
		putRow(1'b0, 23'h012347, 1'b0);
		// Two pages in turn, every one a miss
		putRow(1'b0, 23'h000100, 1'b0);
		putRow(1'b0, 23'h7FFFF8, 1'b0);
		putRow(1'b0, 23'h000101, 1'b0);
		putRow(1'b0, 23'h7FFFFA, 1'b0);
		// Refused writes leave the open page alone
		putRow(1'b1, 23'h000400, 1'b1);
		putRow(1'b0, 23'h7FFFFF, 1'b0);
		putRow(1'b1, 23'h7FFFF9, 1'b1);
		putRow(1'b0, 23'h000102, 1'b0);
		prevAddr = 23'h000102;
		// Random reads, about half stay in the previous page
		for (int i = 0; i < randomRows; i++) begin
			draw = $random(seed);
			if (draw[31]) begin
				nextAddr = {prevAddr[romAddrBits-1:pageBits], draw[pageBits-1:0]};
			end else begin
				nextAddr = draw[romAddrBits-1:0];
			end
			putRow(1'b0, nextAddr, 1'b0);
			prevAddr = nextAddr;
		end
	endtask

	// One Wishbone classic transfer, started on a falling edge
	task automatic runRow(input stimRow row);
		int cycles;
		bit seen;
		int expLatency;
		logic [romAddrBits-pageBits-1:0] rowPage;
		rowPage = row.addr[romAddrBits-1:pageBits];
		// err already in the cycle that the sampling edge opens
		if (row.expErr) begin
			expLatency = 0;
		end else if (rowPage == openPage) begin
			expLatency = hitCycles;
		end else begin
			expLatency = missCycles;
		end
		cyc = 1'b1;
		stb = 1'b1;
		we = row.we;
		adr = row.addr;
		wrData = row.addr[15:0];
		cycles = 0;
		seen = 1'b0;
		// Count edges from the sampling edge to the response cycle
		while (!seen && cycles <= missCycles + 2) begin
			@(negedge clk);
			if (ack || err) begin
				seen = 1'b1;
			end else begin
				cycles++;
			end
		end
		if (!seen) begin
			$display("No ack or err for address %h within %0d cycles", row.addr, cycles);
			errorCount++;
		end else if (row.expErr) begin
			checkErr("err", err, 1'b1);
			checkErr("ack", ack, 1'b0);
			checkLatency("err latency", cycles, expLatency);
		end else begin
			checkErr("ack", ack, 1'b1);
			checkErr("err", err, 1'b0);
			checkLatency("ack latency", cycles, expLatency);
			checkData("rdData", rdData, expectedWord(row.addr));
			// Byte address on the pins, word address with a zero bit
			checkPinAddr("flashAddr", flashAddr, {row.addr, 1'b0});
		end
		// Strobe held one more cycle, the response must not repeat
		@(negedge clk);
		checkErr("ack", ack, 1'b0);
		checkErr("err", err, 1'b0);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		// Slave is back in idle after this one
		@(negedge clk);
		if (!row.we) begin
			openPage = rowPage;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		wrData = '0;
		rowFill = 0;
		errorCount = 0;
		checkCount = 0;
		openPage = '0;
		seed = 32'h6eb5a917;
		buildTable();
		repeat (resetCycles) @(negedge clk);
		rst = 1'b1;
		// Quiet bus until the first strobe
		repeat (3) begin
			@(negedge clk);
			checkErr("ack", ack, 1'b0);
			checkErr("err", err, 1'b0);
		end
		// Read mode on the control pins
		checkErr("flashChipEn", flashChipEn, 1'b0);
		checkErr("flashOutEn", flashOutEn, 1'b0);
		checkErr("flashWriteEn", flashWriteEn, 1'b1);
		checkErr("flashByte", flashByte, 1'b1);
		for (int i = 0; i < tableRows; i++) begin
			runRow(stimTable[i]);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
